/* cap_settings.svh */
// Frame capture defaults.

`ifndef CAP_SETTINGS_SVH
`define CAP_SETTINGS_SVH

// Words written per Avalon burst.
`define CAP_BURST_LEN 16

// FIFO entries, a power of two and at least two bursts deep.
`define CAP_FIFO_DEPTH 64

// Default frame geometry, VGA.
`define CAP_H_PIXELS 640
`define CAP_V_LINES 480

`endif

/* cap_pkg.sv */
// Frame capture types.

`default_nettype none

package cap_pkg;

    // byte address on the Avalon side.
    typedef logic [25:0] addr_t;

    // one RGB565 pixel, also the memory word.
    typedef logic [15:0] pixel_t;

endpackage

`default_nettype wire

/* pixel_fifo_if.sv */
// Pixel FIFO read port.

`default_nettype none

interface pixel_fifo_if;
    import cap_pkg::*;

    logic   rd;      // pops the head entry on the clock edge.
    pixel_t rdata;   // head entry, valid while not empty.
    logic   ready;   // at least one burst is buffered.
    logic   empty;

    modport fifo (
        input  rd,
        output rdata,
        output ready,
        output empty
    );

    modport master (
        output rd,
        input  rdata,
        input  ready,
        input  empty
    );

endinterface

`default_nettype wire

/* pixel_fifo.sv */
// Synchronous pixel FIFO.

`default_nettype none
`include "cap_settings.svh"

module pixel_fifo #(
    parameter type T     = cap_pkg::pixel_t,
    parameter int  DEPTH = `CAP_FIFO_DEPTH
) (
    input  logic CLK,
    input  logic RST,
    input  logic clear,
    input  logic push,
    input  T     wdata,
    pixel_fifo_if.fifo f,
    output logic overflow
);

    localparam int BURST_LEN = `CAP_BURST_LEN;
    localparam int AW        = $clog2(DEPTH);
    localparam int LW        = $clog2(DEPTH + 1);

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [LW-1:0] level;
    logic          full;
    logic          do_push;
    logic          do_pop;

    assign full    = (level == LW'(DEPTH));
    assign f.empty = (level == '0);
    assign f.ready = (level >= LW'(BURST_LEN));
    assign f.rdata = mem[rd_ptr];   // head is read straight from the array.

    assign do_pop  = f.rd && !f.empty;
    assign do_push = push && (!full || do_pop);   // a pop frees the slot in time.

    always_ff @(posedge CLK) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // pointers wrap on their own since the depth is a power of two.
    always_ff @(posedge CLK) begin
        if (RST || clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (RST || clear) begin
            level <= '0;
        end else begin
            case ({do_push, do_pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    // sticky until the next frame starts.
    always_ff @(posedge CLK) begin
        if (RST || clear) begin
            overflow <= 1'b0;
        end else if (push && !do_push) begin
            overflow <= 1'b1;
        end
    end

    // The master only pops after it has seen a full burst buffered.
    a_no_pop_empty : assert property (
        @(posedge CLK) disable iff (RST)
        !(f.rd && f.empty)
    ) else $error("ERR pixel_fifo rd while empty, level=%h", level);

    a_level_bound : assert property (
        @(posedge CLK) disable iff (RST)
        level <= LW'(DEPTH)
    ) else $error("ERR pixel_fifo level=%h exceeds depth", level);

endmodule

`default_nettype wire

/* frame_gate.sv */
// Frame admission gate.

`default_nettype none
`include "cap_settings.svh"

module frame_gate #(
    parameter int H_PIXELS = `CAP_H_PIXELS,
    parameter int V_LINES  = `CAP_V_LINES
) (
    input  logic            CLK,
    input  logic            RST,
    input  logic            cap_req,
    input  logic            vblank,
    input  logic            pix_valid,
    input  cap_pkg::pixel_t pix_data,
    input  logic            cap_done,
    output logic            frame_start,
    output logic            push,
    output cap_pkg::pixel_t pixel,
    output logic            busy
);

    localparam int FRAME_WORDS = H_PIXELS * V_LINES;
    localparam int CW          = $clog2(FRAME_WORDS + 1);

    typedef enum logic [1:0] {IDLE, ARMED, CAPTURING} state_t;

    state_t        state;
    logic          vblank_q;
    logic          vblank_rise;
    logic          admit;
    logic [CW-1:0] pix_cnt;

    assign vblank_rise = vblank && !vblank_q;
    assign admit       = (state == CAPTURING) && pix_valid && !vblank &&
                         (pix_cnt != CW'(FRAME_WORDS));   // extra pixels are ignored.
    assign busy        = (state != IDLE) && !cap_done;   // drops together with done.

    always_ff @(posedge CLK) begin
        if (RST) begin
            state       <= IDLE;
            vblank_q    <= 1'b0;
            frame_start <= 1'b0;
            push        <= 1'b0;
            pix_cnt     <= '0;
        end else begin
            vblank_q    <= vblank;
            frame_start <= 1'b0;
            push        <= admit;
            case (state)
                IDLE: begin
                    if (cap_req) begin
                        state <= ARMED;
                    end
                end
                ARMED: begin
                    if (vblank_rise) begin
                        state       <= CAPTURING;
                        frame_start <= 1'b1;   // clears the FIFO before the first push.
                        pix_cnt     <= '0;
                    end
                end
                CAPTURING: begin
                    if (admit) begin
                        pix_cnt <= pix_cnt + 1'b1;
                    end
                    if (cap_done) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (admit) begin
            pixel <= pix_data;
        end
    end

    // Every push lands well before the master reports the frame written.
    a_push_in_frame : assert property (
        @(posedge CLK) disable iff (RST)
        push |-> state == CAPTURING
    ) else $error("ERR frame_gate push outside capture, state=%h", state);

endmodule

`default_nettype wire

/* cap_ctrl.sv */
// Avalon-MM burst write master.

`default_nettype none
`include "cap_settings.svh"

module cap_ctrl #(
    parameter int H_PIXELS = `CAP_H_PIXELS,
    parameter int V_LINES  = `CAP_V_LINES
) (
    input  logic            CLK,
    input  logic            RST,
    input  logic            frame_start,
    input  cap_pkg::addr_t  cap_base,
    pixel_fifo_if.master    f,
    input  logic            avm_waitrequest,
    output cap_pkg::addr_t  avm_address,
    output logic            avm_write,
    output cap_pkg::pixel_t avm_writedata,
    output logic            cap_done
);

    import cap_pkg::*;

    localparam int    BURST_LEN   = `CAP_BURST_LEN;
    localparam int    BW          = $clog2(BURST_LEN);
    localparam int    FRAME_WORDS = H_PIXELS * V_LINES;
    localparam addr_t LAST_OFFSET = addr_t'((FRAME_WORDS - 1) * 2);

    typedef enum logic [1:0] {
        HALT    = 2'b00,
        PREREAD = 2'b01,
        WRITING = 2'b10,
        STANDBY = 2'b11
    } state_t;

    state_t        state;
    state_t        state_nxt;
    addr_t         offset;
    logic [BW-1:0] burst_cnt;
    pixel_t        data_q;
    logic          accept;
    logic          burst_end;
    logic          frame_end;

    assign avm_write     = (state == WRITING);
    assign avm_address   = cap_base + offset;
    assign avm_writedata = data_q;

    assign accept    = avm_write && !avm_waitrequest;
    assign burst_end = (burst_cnt == BW'(BURST_LEN - 1));
    assign frame_end = (offset == LAST_OFFSET);

    // One word stays staged in data_q, so the last write of a burst pops nothing.
    assign f.rd = (state == PREREAD) || (accept && !burst_end);

    always_ff @(posedge CLK) begin
        if (RST || frame_start) begin
            state <= HALT;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            HALT:    if (f.ready) state_nxt = PREREAD;
            PREREAD: state_nxt = WRITING;
            WRITING: begin
                if (accept && burst_end) begin
                    state_nxt = frame_end ? HALT : STANDBY;
                end
            end
            STANDBY: if (f.ready) state_nxt = PREREAD;
            default: state_nxt = HALT;
        endcase
    end

    // byte offset into the frame, one word per accepted write.
    always_ff @(posedge CLK) begin
        if (RST || frame_start || state == HALT) begin
            offset <= '0;
        end else if (accept) begin
            offset <= offset + addr_t'(2);
        end
    end

    always_ff @(posedge CLK) begin
        if (RST || state == PREREAD) begin
            burst_cnt <= '0;
        end else if (accept) begin
            burst_cnt <= burst_cnt + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (f.rd) begin
            data_q <= f.rdata;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            cap_done <= 1'b0;
        end else begin
            cap_done <= accept && burst_end && frame_end;
        end
    end

    // A stalled write must present the same word until the slave takes it.
    a_stall_stable : assert property (
        @(posedge CLK) disable iff (RST || frame_start)
        avm_write && avm_waitrequest |=> $stable(avm_address) && $stable(avm_writedata)
    ) else $error("ERR cap_ctrl stall changed avm_address=%h avm_writedata=%h",
                  avm_address, avm_writedata);

endmodule

`default_nettype wire

/* capture_top.sv */
// Frame capture top level.

`default_nettype none
`include "cap_settings.svh"

module capture_top #(
    parameter int H_PIXELS = `CAP_H_PIXELS,
    parameter int V_LINES  = `CAP_V_LINES
) (
    input  logic            CLK,
    input  logic            RST,
    input  logic            cap_req,
    input  cap_pkg::addr_t  cap_base,
    input  logic            vblank,
    input  logic            pix_valid,
    input  cap_pkg::pixel_t pix_data,
    output cap_pkg::addr_t  avm_address,
    output logic            avm_write,
    output cap_pkg::pixel_t avm_writedata,
    input  logic            avm_waitrequest,
    output logic            busy,
    output logic            done,
    output logic            overflow
);

    import cap_pkg::*;

    logic   frame_start;
    logic   push;
    pixel_t pixel;

    pixel_fifo_if fifo_rd ();

    frame_gate #(
        .H_PIXELS (H_PIXELS),
        .V_LINES  (V_LINES)
    ) gate0 (
        .CLK         (CLK),
        .RST         (RST),
        .cap_req     (cap_req),
        .vblank      (vblank),
        .pix_valid   (pix_valid),
        .pix_data    (pix_data),
        .cap_done    (done),
        .frame_start (frame_start),
        .push        (push),
        .pixel       (pixel),
        .busy        (busy)
    );

    pixel_fifo #(
        .T     (pixel_t),
        .DEPTH (`CAP_FIFO_DEPTH)
    ) fifo0 (
        .CLK      (CLK),
        .RST      (RST),
        .clear    (frame_start),
        .push     (push),
        .wdata    (pixel),
        .f        (fifo_rd.fifo),
        .overflow (overflow)
    );

    cap_ctrl #(
        .H_PIXELS (H_PIXELS),
        .V_LINES  (V_LINES)
    ) ctrl0 (
        .CLK             (CLK),
        .RST             (RST),
        .frame_start     (frame_start),
        .cap_base        (cap_base),
        .f               (fifo_rd.master),
        .avm_waitrequest (avm_waitrequest),
        .avm_address     (avm_address),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .cap_done        (done)
    );

endmodule

`default_nettype wire

/* tb_mem_model.sv */
// Avalon slave model.

`default_nettype none

module tb_mem_model (
    input  logic            CLK,
    input  cap_pkg::addr_t  avm_address,
    input  logic            avm_write,
    input  cap_pkg::pixel_t avm_writedata,
    output logic            avm_waitrequest
);

    import cap_pkg::*;

    localparam logic [31:0] SEED = 32'h6a86cbbc;

    addr_t       log_addr [$];         // accepted writes, oldest first.
    pixel_t      log_data [$];
    logic [31:0] lfsr_state = SEED;

    // Galois form of x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    initial begin
        avm_waitrequest = 1'b0;
    end

    // The stall for the next edge is chosen here, so the write that the master
    // shows now is accepted at that edge exactly when no stall was chosen.
    always @(negedge CLK) begin
        logic stall;
        stall      = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
        stall      = stall & lfsr_state[0];   // two bits give about one cycle in four.
        lfsr_state = lfsr_next(lfsr_state);
        avm_waitrequest = stall;
        if (avm_write && !stall) begin
            log_addr.push_back(avm_address);
            log_data.push_back(avm_writedata);
        end
    end

endmodule

`default_nettype wire

/* tb_capture.sv */
// Frame capture testbench.

`default_nettype none
`include "cap_settings.svh"

module tb_capture;

    import cap_pkg::*;

    localparam int     H_PIXELS    = 32;
    localparam int     V_LINES     = 4;
    localparam int     FRAME_WORDS = H_PIXELS * V_LINES;
    localparam int     BURST_LEN   = `CAP_BURST_LEN;
    localparam int     PERIOD      = 100;
    localparam int     H_GAP       = 32;   // idle cycles after each line.
    localparam int     TIMEOUT     = 4 * FRAME_WORDS * 8 * PERIOD;
    localparam pixel_t STRAY_TAG   = 16'hE000;
    localparam pixel_t TAG0        = 16'h1000;
    localparam pixel_t TAG1        = 16'h5000;
    localparam addr_t  BASE0       = 26'h0010000;
    localparam addr_t  BASE1       = 26'h1234500;

    logic   CLK;
    logic   RST;
    logic   cap_req;
    addr_t  cap_base;
    logic   vblank;
    logic   pix_valid;
    pixel_t pix_data;
    addr_t  avm_address;
    logic   avm_write;
    pixel_t avm_writedata;
    logic   avm_waitrequest;
    logic   busy;
    logic   done;
    logic   overflow;
    int     done_count = 0;

    capture_top #(
        .H_PIXELS (H_PIXELS),
        .V_LINES  (V_LINES)
    ) dut0 (
        .CLK             (CLK),
        .RST             (RST),
        .cap_req         (cap_req),
        .cap_base        (cap_base),
        .vblank          (vblank),
        .pix_valid       (pix_valid),
        .pix_data        (pix_data),
        .avm_address     (avm_address),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_waitrequest (avm_waitrequest),
        .busy            (busy),
        .done            (done),
        .overflow        (overflow)
    );

    tb_mem_model mem0 (
        .CLK             (CLK),
        .avm_address     (avm_address),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_waitrequest (avm_waitrequest)
    );

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    initial begin
        #(TIMEOUT);
        fail_now("watchdog expired before the test sequence finished");
    end

    // done is registered, so it is steady at the falling edge.
    always @(negedge CLK) begin
        if (done) begin
            done_count = done_count + 1;
            assert (mem0.log_addr.size() == done_count * FRAME_WORDS) else
                fail_now($sformatf("ERR accepted writes=%h expected=%h at done",
                                   mem0.log_addr.size(), done_count * FRAME_WORDS));
        end
    end

    a_stall_hold : assert property (
        @(posedge CLK) disable iff (RST)
        avm_write && avm_waitrequest |=>
            avm_write && $stable(avm_address) && $stable(avm_writedata)
    ) else fail_now($sformatf("ERR avm_address=%h avm_writedata=%h changed while stalled",
                              avm_address, avm_writedata));

    a_in_window : assert property (
        @(posedge CLK) disable iff (RST)
        avm_write |-> addr_t'(avm_address - cap_base) < addr_t'(2 * FRAME_WORDS)
    ) else fail_now($sformatf("ERR avm_address=%h outside the window at cap_base=%h",
                              avm_address, cap_base));

    // bursts start and end on a 16-word boundary of the frame.
    a_burst_edge : assert property (
        @(posedge CLK) disable iff (RST)
        ($rose(avm_write) || $fell(avm_write)) |->
            (addr_t'(avm_address - cap_base) & addr_t'(2 * BURST_LEN - 1)) == '0
    ) else fail_now($sformatf("ERR avm_address=%h off a burst boundary, cap_base=%h",
                              avm_address, cap_base));

    a_no_overflow : assert property (
        @(posedge CLK) disable iff (RST)
        !overflow
    ) else fail_now($sformatf("ERR overflow=%h", overflow));

    a_done_pulse : assert property (
        @(posedge CLK) disable iff (RST)
        done |=> !done
    ) else fail_now($sformatf("ERR done=%h held for more than one cycle", done));

    a_busy_low_at_done : assert property (
        @(posedge CLK) disable iff (RST)
        done |-> !busy
    ) else fail_now($sformatf("ERR busy=%h done=%h busy still high at done", busy, done));

    a_busy_falls_with_done : assert property (
        @(posedge CLK) disable iff (RST)
        $fell(busy) |-> done
    ) else fail_now($sformatf("ERR busy=%h done=%h busy fell without done", busy, done));

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge CLK);
            pix_valid = 1'b0;
        end
    endtask

    task automatic pulse_vblank(input int n);
        @(negedge CLK);
        pix_valid = 1'b0;
        vblank    = 1'b1;
        repeat (n) @(negedge CLK);
        vblank = 1'b0;
    endtask

    task automatic send_stray(input int n, input pixel_t tag);
        for (int i = 0; i < n; i++) begin
            @(negedge CLK);
            pix_valid = 1'b1;
            pix_data  = tag + pixel_t'(i);
        end
        @(negedge CLK);
        pix_valid = 1'b0;
    endtask

    task automatic request_capture(input addr_t base);
        @(negedge CLK);
        cap_base = base;
        cap_req  = 1'b1;
        @(negedge CLK);
        cap_req = 1'b0;
        assert (busy) else fail_now($sformatf("ERR busy=%h after cap_req", busy));
    endtask

    // pixel k of the frame carries tag plus k.
    task automatic send_frame(input pixel_t tag);
        pulse_vblank(4);
        for (int line = 0; line < V_LINES; line++) begin
            for (int x = 0; x < H_PIXELS; x++) begin
                @(negedge CLK);
                pix_valid = 1'b1;
                pix_data  = tag + pixel_t'(line * H_PIXELS + x);
            end
            idle_cycles(H_GAP);
        end
        send_stray(6, STRAY_TAG + 16'h0200);   // beyond the frame count.
    endtask

    task automatic wait_capture(input int n);
        int cycles;
        cycles = 0;
        while (done_count < n && cycles < FRAME_WORDS * 8) begin
            @(posedge CLK);
            cycles++;
        end
        assert (done_count >= n) else fail_now("capture did not report done in time");
    endtask

    task automatic check_capture(input int n, input addr_t base, input pixel_t tag);
        int     first;
        addr_t  exp_addr;
        pixel_t exp_data;
        first = n * FRAME_WORDS;
        for (int i = 0; i < FRAME_WORDS; i++) begin
            exp_addr = base + addr_t'(2 * i);
            exp_data = tag + pixel_t'(i);
            assert (mem0.log_data[first + i][15:12] != STRAY_TAG[15:12]) else
                fail_now("a pixel sent outside the capture window reached memory");
            assert (mem0.log_addr[first + i] == exp_addr) else
                fail_now($sformatf("ERR avm_address=%h expected=%h",
                                   mem0.log_addr[first + i], exp_addr));
            assert (mem0.log_data[first + i] == exp_data) else
                fail_now($sformatf("ERR avm_writedata=%h expected=%h",
                                   mem0.log_data[first + i], exp_data));
        end
    endtask

    initial begin
        RST       = 1'b1;
        cap_req   = 1'b0;
        cap_base  = '0;
        vblank    = 1'b0;
        pix_valid = 1'b0;
        pix_data  = '0;
        repeat (5) @(negedge CLK);
        RST = 1'b0;

        // first capture, with a blank and pixels ahead of the request.
        pulse_vblank(3);
        send_stray(12, STRAY_TAG);
        request_capture(BASE0);
        send_stray(8, STRAY_TAG + 16'h0100);   // armed but no vblank edge yet.
        send_frame(TAG0);
        wait_capture(1);
        check_capture(0, BASE0, TAG0);

        idle_cycles(10);
        request_capture(BASE1);
        send_frame(TAG1);
        wait_capture(2);
        check_capture(1, BASE1, TAG1);

        idle_cycles(20);
        if (done_count == 2) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            fail_now($sformatf("ERR done_count=%h expected=%h", done_count, 2));
        end
    end

endmodule

`default_nettype wire

/* capture_top.f */
+incdir+.
cap_pkg.sv
pixel_fifo_if.sv
pixel_fifo.sv
frame_gate.sv
cap_ctrl.sv
capture_top.sv
tb_mem_model.sv
tb_capture.sv

/* Makefile */
# Verilator build and run for the frame capture testbench.

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_capture
FILELIST  := capture_top.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_TEXT := SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
